/* uscope_stream_capture.f */
+incdir+verilog
verilog/scope_reg_pkg.sv
verilog/scope_stream_pkg.sv
verilog/scope_ctrl.sv
verilog/sample_timebase.sv
verilog/channel_extractor.sv
verilog/capture_buffer.sv
verilog/uscope_stream_capture.sv
dv/uscope_stream_capture_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the stream scope testbench with Verilator, run it and judge the log
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module uscope_stream_capture_tb \
    -f uscope_stream_capture.f -o uscope_sim

./obj_dir/uscope_sim | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
    echo "run_sim: simulation passed"
else
    echo "run_sim: simulation failed"
    exit 1
fi

/* dv/uscope_stream_capture_tb.sv */
// Directed testbench for the stream scope with stimulus tasks, typed compare tasks and timeout
`default_nettype none

`include "scope_macros.svh"

module uscope_stream_capture_tb
    import scope_reg_pkg::*, scope_stream_pkg::*;
();

    // Five captures of at most 16 rows at divider 63 with full readbacks stay far below this
    localparam int TIMEOUT_CYCLES = 20000;
    // One capture at divider 63 takes about 1024 cycles
    localparam int DONE_WAIT_CYCLES = 2000;
    localparam row_index_t LAST_ROW = row_index_t'(`SCOPE_DEPTH - 1);
    // CONTROL words, arm at bit 0 and external capture at bit 24
    localparam reg_data_t ARM_WORD = 32'h0000_0001;
    localparam reg_data_t EXT_WORD = 32'h0100_0000;

    logic           clock;
    logic           rst_n;
    logic           reg_write;
    reg_addr_t      reg_addr;
    reg_data_t      reg_data;
    logic           in_valid;
    sample_t        in_data;
    dest_t          in_dest;
    logic           sampling_pulse;
    logic           rd_strobe;
    row_index_t     rd_row;
    channel_index_t rd_channel;
    wire            rd_valid;
    wire sample_t   rd_data;
    wire            busy;
    wire            done;

    // Reference model of the selectors and of what each channel holds
    dest_t   model_sel [`SCOPE_N_CHANNELS];
    sample_t model_held [`SCOPE_N_CHANNELS];
    sample_t expected_rows [`SCOPE_DEPTH][`SCOPE_N_CHANNELS];
    int      done_count = 0;
    int      cycle_count = 0;

    uscope_stream_capture UUT (
        .clock(clock),
        .rst_n(rst_n),
        .reg_write(reg_write),
        .reg_addr(reg_addr),
        .reg_data(reg_data),
        .in_valid(in_valid),
        .in_data(in_data),
        .in_dest(in_dest),
        .sampling_pulse(sampling_pulse),
        .rd_strobe(rd_strobe),
        .rd_row(rd_row),
        .rd_channel(rd_channel),
        .rd_valid(rd_valid),
        .rd_data(rd_data),
        .busy(busy),
        .done(done)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #20 clock = ~clock;
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "stopped at the first error");
    endtask

    // Hard limit on the whole run
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            fail_run("simulation ran past its cycle limit");
        end
    end

    // Outputs are sampled at the falling edge, away from the driving edge
    always @(negedge clock) begin
        if (done === 1'b1) begin
            done_count <= done_count + 1;
        end
    end

    task automatic check_sample(input string name, input sample_t actual, input sample_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED %s: expected 0x%h, got 0x%h", name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED %s: expected 0x%h, got 0x%h", name, expected, actual));
        end
    endtask

    task automatic check_row_count(input string name, input row_index_t actual,
                                   input row_index_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("CHECK FAILED %s: expected 0x%h, got 0x%h", name, expected, actual));
        end
    endtask

    task automatic reg_wr(input reg_addr_t addr, input reg_data_t data);
        @(posedge clock);
        reg_write <= 1'b1;
        reg_addr  <= addr;
        reg_data  <= data;
        @(posedge clock);
        reg_write <= 1'b0;
    endtask

    // Selector registers sit one word apart from SELECTOR_0
    task automatic set_selector(input int channel, input dest_t tag);
        reg_wr(reg_addr_t'(SELECTOR_0) + reg_addr_t'(4 * channel), reg_data_t'(tag));
        model_sel[channel] = tag;
    endtask

    task automatic stream_send(input dest_t tag, input sample_t data);
        @(posedge clock);
        in_valid <= 1'b1;
        in_dest  <= tag;
        in_data  <= data;
        @(posedge clock);
        in_valid <= 1'b0;
        // Every channel following this tag now holds the new sample
        for (int c = 0; c < `SCOPE_N_CHANNELS; c++) begin
            if (model_sel[c] == tag) begin
                model_held[c] = data;
            end
        end
    endtask

    task automatic ext_pulse();
        @(posedge clock);
        sampling_pulse <= 1'b1;
        @(posedge clock);
        sampling_pulse <= 1'b0;
    endtask

    // rd_valid must still be low in the strobe cycle and high one cycle later
    task automatic read_sample(input row_index_t row, input channel_index_t channel,
                               output sample_t value);
        @(posedge clock);
        rd_strobe  <= 1'b1;
        rd_row     <= row;
        rd_channel <= channel;
        @(negedge clock);
        check_bit("rd_valid", rd_valid, 1'b0);
        @(posedge clock);
        rd_strobe <= 1'b0;
        @(negedge clock);
        check_bit("rd_valid", rd_valid, 1'b1);
        value = rd_data;
    endtask

    task automatic arm_capture(input reg_data_t mode);
        reg_wr(CONTROL, mode | ARM_WORD);
        @(negedge clock);
        check_bit("busy", busy, 1'b1);
    endtask

    // busy falls in the done cycle and done lasts a single cycle
    task automatic wait_done();
        int waited;
        waited = 0;
        @(negedge clock);
        while (done !== 1'b1) begin
            if (waited == DONE_WAIT_CYCLES) begin
                fail_run("done never arrived");
            end
            waited++;
            @(negedge clock);
        end
        check_bit("busy", busy, 1'b0);
        @(negedge clock);
        check_bit("done", done, 1'b0);
    endtask

    // Done comes `SCOPE_DEPTH tick periods of divider+1 cycles after busy rose
    // The extra cycle is the one that wait_done spends checking that done has dropped
    task automatic check_capture_time(input int divider_value, input int elapsed);
        int expected;
        expected = `SCOPE_DEPTH * (divider_value + 1) + 1;
        if (elapsed != expected) begin
            fail_run($sformatf("CHECK FAILED done: expected 0x%h cycles after arm, got 0x%h",
                               expected, elapsed));
        end
    endtask

    task automatic check_done_once(input int start_count);
        repeat (4) @(negedge clock);
        if (done_count != start_count + 1) begin
            fail_run($sformatf("done pulsed %0d times in one capture", done_count - start_count));
        end
    endtask

    task automatic fill_expected_from_held();
        for (int r = 0; r < `SCOPE_DEPTH; r++) begin
            for (int c = 0; c < `SCOPE_N_CHANNELS; c++) begin
                expected_rows[r][c] = model_held[c];
            end
        end
    endtask

    task automatic check_capture();
        sample_t value;
        for (int r = 0; r < `SCOPE_DEPTH; r++) begin
            for (int c = 0; c < `SCOPE_N_CHANNELS; c++) begin
                read_sample(row_index_t'(r), channel_index_t'(c), value);
                check_sample($sformatf("rd_data row %0d channel %0d", r, c), value,
                             expected_rows[r][c]);
            end
        end
    endtask

    // Counts rows whose every channel reads back as expected
    task automatic count_matching_rows(output int rows);
        sample_t value;
        logic    row_ok;
        rows = 0;
        for (int r = 0; r < `SCOPE_DEPTH; r++) begin
            row_ok = 1'b1;
            for (int c = 0; c < `SCOPE_N_CHANNELS; c++) begin
                read_sample(row_index_t'(r), channel_index_t'(c), value);
                if (value !== expected_rows[r][c]) begin
                    row_ok = 1'b0;
                end
            end
            if (row_ok) begin
                rows++;
            end
        end
    endtask

    // New data on every channel, two quiet cycles, then the pulse that takes row k
    task automatic capture_external_rows(input int first, input int count);
        for (int k = first; k < first + count; k++) begin
            for (int c = 0; c < `SCOPE_N_CHANNELS; c++) begin
                stream_send(model_sel[c], sample_t'($urandom));
            end
            repeat (2) @(posedge clock);
            for (int c = 0; c < `SCOPE_N_CHANNELS; c++) begin
                expected_rows[k][c] = model_held[c];
            end
            ext_pulse();
        end
    endtask

    task automatic check_reset_state();
        @(negedge clock);
        check_bit("busy", busy, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("rd_valid", rd_valid, 1'b0);
        fill_expected_from_held();
        check_capture();
    endtask

    task automatic check_static_channels();
        int start_done;
        int armed_at;
        set_selector(0, 8'd3);
        set_selector(1, 8'd7);
        set_selector(2, 8'd7);
        set_selector(3, 8'd9);
        reg_wr(DIVIDER, 32'd5);
        // Offset 0x14 is unmapped, so channel 0 keeps following tag 3
        reg_wr(8'h14, 32'd9);
        stream_send(8'd7, 16'h1234);
        stream_send(8'd3, 16'h0a0a);
        stream_send(8'd5, 16'hdead);
        stream_send(8'd7, 16'h5678);
        stream_send(8'd200, 16'hbeef);
        stream_send(8'd3, 16'h0c0c);
        fill_expected_from_held();
        start_done = done_count;
        arm_capture(32'h0);
        armed_at = cycle_count;
        wait_done();
        check_capture_time(5, cycle_count - armed_at);
        check_done_once(start_done);
        check_capture();
    endtask

    task automatic check_external_capture();
        int start_done;
        set_selector(0, 8'h11);
        set_selector(1, 8'h22);
        set_selector(2, 8'h33);
        set_selector(3, 8'h44);
        reg_wr(CONTROL, EXT_WORD);
        start_done = done_count;
        arm_capture(EXT_WORD);
        capture_external_rows(0, `SCOPE_DEPTH);
        wait_done();
        check_done_once(start_done);
        // The row counter has wrapped to 0, so a write while idle would land in row 0
        stream_send(model_sel[0], ~model_held[0]);
        repeat (2) @(posedge clock);
        ext_pulse();
        check_capture();
    endtask

    task automatic check_arm_while_busy();
        int start_done;
        int rows;
        start_done = done_count;
        arm_capture(EXT_WORD);
        capture_external_rows(0, `SCOPE_DEPTH / 2);
        // A second arm halfway through must not restart the row counter
        reg_wr(CONTROL, EXT_WORD | ARM_WORD);
        capture_external_rows(`SCOPE_DEPTH / 2, `SCOPE_DEPTH / 2);
        wait_done();
        check_done_once(start_done);
        count_matching_rows(rows);
        if (rows == 0) begin
            fail_run("no captured row matched the samples sent");
        end
        check_row_count("last row written", row_index_t'(rows - 1), LAST_ROW);
    endtask

    task automatic check_rearm_internal();
        int start_done;
        int armed_at;
        reg_wr(DIVIDER, 32'd63);
        for (int c = 0; c < `SCOPE_N_CHANNELS; c++) begin
            stream_send(model_sel[c], sample_t'($urandom));
        end
        fill_expected_from_held();
        start_done = done_count;
        arm_capture(32'h0);
        armed_at = cycle_count;
        wait_done();
        check_capture_time(63, cycle_count - armed_at);
        check_done_once(start_done);
        check_capture();
    endtask

    initial begin
        void'($urandom(32'h77b));
        rst_n          = 1'b0;
        reg_write      = 1'b0;
        reg_addr       = '0;
        reg_data       = '0;
        in_valid       = 1'b0;
        in_data        = '0;
        in_dest        = '0;
        sampling_pulse = 1'b0;
        rd_strobe      = 1'b0;
        rd_row         = '0;
        rd_channel     = '0;
        for (int c = 0; c < `SCOPE_N_CHANNELS; c++) begin
            model_sel[c]  = '0;
            model_held[c] = '0;
        end
        repeat (16) @(posedge clock);
        rst_n <= 1'b1;

        check_reset_state();
        check_static_channels();
        check_external_capture();
        check_arm_while_busy();
        check_rearm_internal();

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/uscope_stream_capture.sv */
// Stream scope top level: control, timebase, per channel extractors and capture buffer
`default_nettype none

`include "scope_macros.svh"

module uscope_stream_capture
    import scope_reg_pkg::*, scope_stream_pkg::*;
(
    input  wire                 clock,
    input  wire                 rst_n,
    // Register writes
    input  wire                 reg_write,
    input  wire reg_addr_t      reg_addr,
    input  wire reg_data_t      reg_data,
    // Tagged sample stream
    input  wire                 in_valid,
    input  wire sample_t        in_data,
    input  wire dest_t          in_dest,
    // External timebase
    input  wire                 sampling_pulse,
    // Buffer readback
    input  wire                 rd_strobe,
    input  wire row_index_t     rd_row,
    input  wire channel_index_t rd_channel,
    output wire                 rd_valid,
    output wire sample_t        rd_data,
    // Capture status
    output wire                 busy,
    output wire                 done
);

    wire                        run;
    wire                        ext_select;
    wire [`SCOPE_DIV_WIDTH-1:0] divider;
    wire                        tick;
    wire                        row_write;
    wire row_index_t            write_row;
    wire dest_t                 selectors [`SCOPE_N_CHANNELS-1:0];
    wire sample_t               held_samples [`SCOPE_N_CHANNELS-1:0];

    scope_ctrl ctrl (
        .clock(clock),
        .rst_n(rst_n),
        .reg_write(reg_write),
        .reg_addr(reg_addr),
        .reg_data(reg_data),
        .tick(tick),
        .run(run),
        .ext_select(ext_select),
        .divider(divider),
        .selectors(selectors),
        .row_write(row_write),
        .write_row(write_row),
        .busy(busy),
        .done(done)
    );

    sample_timebase timebase (
        .clock(clock),
        .rst_n(rst_n),
        .run(run),
        .ext_select(ext_select),
        .divider(divider),
        .sampling_pulse(sampling_pulse),
        .tick(tick)
    );

    // Every extractor sees the whole stream and keeps only its own tag
    generate
        for (genvar i = 0; i < `SCOPE_N_CHANNELS; i++) begin : g_channel
            channel_extractor extractor (
                .clock(clock),
                .rst_n(rst_n),
                .selector(selectors[i]),
                .in_valid(in_valid),
                .in_data(in_data),
                .in_dest(in_dest),
                .held_sample(held_samples[i])
            );
        end
    endgenerate

    capture_buffer buffer (
        .clock(clock),
        .rst_n(rst_n),
        .row_write(row_write),
        .write_row(write_row),
        .row_samples(held_samples),
        .rd_strobe(rd_strobe),
        .rd_row(rd_row),
        .rd_channel(rd_channel),
        .rd_valid(rd_valid),
        .rd_data(rd_data)
    );

endmodule

`default_nettype wire

/* verilog/capture_buffer.sv */
// Capture buffer: row memory written a whole row per cycle, with a registered sample read port
`default_nettype none

`include "scope_macros.svh"

module capture_buffer
    import scope_stream_pkg::*;
(
    input  wire                 clock,
    input  wire                 rst_n,
    // Row write from the capture machine
    input  wire                 row_write,
    input  wire row_index_t     write_row,
    input  wire sample_t        row_samples [`SCOPE_N_CHANNELS-1:0],
    // Strobed read port
    input  wire                 rd_strobe,
    input  wire row_index_t     rd_row,
    input  wire channel_index_t rd_channel,
    output logic                rd_valid,
    output sample_t             rd_data
);

    // One row per tick, one sample per channel in each row
    sample_t mem [0:`SCOPE_DEPTH-1][0:`SCOPE_N_CHANNELS-1];

    // Memory is cleared at reset so rows never written read back as zero
    // A write stores every channel of the row at once
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `SCOPE_DEPTH; r++) begin
                for (int c = 0; c < `SCOPE_N_CHANNELS; c++) begin
                    mem[r][c] <= '0;
                end
            end
        end else if (row_write) begin
            for (int c = 0; c < `SCOPE_N_CHANNELS; c++) begin
                mem[write_row][c] <= row_samples[c];
            end
        end
    end

    // rd_valid follows the strobe by exactly one cycle
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_strobe;
        end
    end

    // Read data is only loaded on a strobe and otherwise keeps the last sample returned
    always_ff @(posedge clock) begin
        if (rd_strobe) begin
            rd_data <= mem[rd_row][rd_channel];
        end
    end

endmodule

`default_nettype wire

/* verilog/channel_extractor.sv */
// Channel extractor: tag compare against the selector and hold of the latest match
`default_nettype none

module channel_extractor
    import scope_stream_pkg::*;
(
    input  wire          clock,
    input  wire          rst_n,
    // Tag this channel follows
    input  wire dest_t   selector,
    // Tagged input stream, shared by all channels
    input  wire          in_valid,
    input  wire sample_t in_data,
    input  wire dest_t   in_dest,
    // Last sample seen with a matching tag
    output sample_t      held_sample
);

    logic tag_match;

    // A sample belongs to this channel when its tag equals the selector
    assign tag_match = in_valid && (in_dest == selector);

    // The held value changes only on a match, so a channel whose tag
    // arrives rarely still shows a stable value at every tick
    // A channel whose tag never arrives keeps reading zero
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            held_sample <= '0;
        end else if (tag_match) begin
            held_sample <= in_data;
        end
    end

endmodule

`default_nettype wire

/* verilog/sample_timebase.sv */
// Sampling timebase: programmable divider and external pulse select giving the sample tick
`default_nettype none

`include "scope_macros.svh"

module sample_timebase (
    input  wire                         clock,
    input  wire                         rst_n,
    input  wire                         run,
    input  wire                         ext_select,
    input  wire [`SCOPE_DIV_WIDTH-1:0]  divider,
    input  wire                         sampling_pulse,
    output logic                        tick
);

    logic [`SCOPE_DIV_WIDTH-1:0] count;
    logic                        count_match;

    // The count reaching the divider value ends one sampling period
    assign count_match = (count == divider);

    // Cycle counter, held at zero outside a capture so each run starts a fresh period
    // A match restarts it, which spaces internal ticks divider+1 cycles apart
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!run || count_match) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // External mode forwards the pulse in the same cycle, with no added latency
    // Either source is masked outside a capture
    assign tick = run && (ext_select ? sampling_pulse : count_match);

endmodule

`default_nettype wire

/* verilog/scope_ctrl.sv */
// Scope control: register decode, arming and the capture state machine with row counter
`default_nettype none

`include "scope_macros.svh"

module scope_ctrl
    import scope_reg_pkg::*, scope_stream_pkg::*;
(
    input  wire                         clock,
    input  wire                         rst_n,
    // Register write strobe
    input  wire                         reg_write,
    input  wire reg_addr_t              reg_addr,
    input  wire reg_data_t              reg_data,
    // Timebase
    input  wire                         tick,
    output logic                        run,
    output logic                        ext_select,
    output logic [`SCOPE_DIV_WIDTH-1:0] divider,
    // Extractors
    output dest_t                       selectors [`SCOPE_N_CHANNELS-1:0],
    // Capture buffer
    output logic                        row_write,
    output row_index_t                  write_row,
    // Status
    output logic                        busy,
    output logic                        done
);

    // Row number of the last row in a capture
    localparam row_index_t LAST_ROW = row_index_t'(`SCOPE_DEPTH - 1);

    capture_state_e state;
    row_index_t     row_count;
    logic           arm_req;

    // An arm request is a CONTROL write with the arm bit set
    // It only starts a capture when the machine is in IDLE
    assign arm_req = reg_write && (reg_addr == CONTROL) && reg_data[CONTROL_ARM_BIT];

    // Stored registers
    // Writes land whatever the capture state is, so selectors can move mid capture
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ext_select <= 1'b0;
            divider    <= '0;
            for (int i = 0; i < `SCOPE_N_CHANNELS; i++) begin
                selectors[i] <= '0;
            end
        end else if (reg_write) begin
            case (reg_addr)
                CONTROL: begin
                    ext_select <= reg_data[CONTROL_EXT_BIT];
                end
                SELECTOR_0: begin
                    selectors[0] <= reg_data[$bits(dest_t)-1:0];
                end
                SELECTOR_1: begin
                    selectors[1] <= reg_data[$bits(dest_t)-1:0];
                end
                SELECTOR_2: begin
                    selectors[2] <= reg_data[$bits(dest_t)-1:0];
                end
                SELECTOR_3: begin
                    selectors[3] <= reg_data[$bits(dest_t)-1:0];
                end
                DIVIDER: begin
                    divider <= reg_data[`SCOPE_DIV_WIDTH-1:0];
                end
                default: begin
                    // Unknown offsets leave every register as it is
                end
            endcase
        end
    end

    // Capture machine
    // The row counter advances on each tick in RUN and wraps back to zero after the last row
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            row_count <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (arm_req) begin
                        state     <= RUN;
                        row_count <= '0;
                    end
                end
                RUN: begin
                    if (tick) begin
                        // The last row moves the machine on to FINISH
                        if (row_count == LAST_ROW) begin
                            state <= FINISH;
                        end
                        row_count <= row_count + 1'b1;
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // The timebase only runs while a capture is in progress
    assign run = (state == RUN);

    // One row per tick, written at the current row count
    assign row_write = run && tick;
    assign write_row = row_count;

    // busy drops in the same cycle that done pulses
    assign busy = (state == RUN);
    assign done = (state == FINISH);

endmodule

`default_nettype wire

/* verilog/scope_stream_pkg.sv */
// Sample, tag, row and channel index types and the capture state enum
`default_nettype none

`include "scope_macros.svh"

package scope_stream_pkg;

    // One data word of the tagged input stream
    typedef logic [15:0] sample_t;

    // Stream destination tag, also used as a channel selector value
    typedef logic [7:0] dest_t;

    // Row number in the capture buffer
    typedef logic [$clog2(`SCOPE_DEPTH)-1:0] row_index_t;

    // Channel number, selecting one sample inside a row
    typedef logic [$clog2(`SCOPE_N_CHANNELS)-1:0] channel_index_t;

    // States of the capture machine
    // IDLE waits for an arm write
    // RUN writes one row per tick until the buffer is full
    // FINISH lasts one cycle and carries the done pulse
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FINISH
    } capture_state_e;

endpackage

`default_nettype wire

/* verilog/scope_reg_pkg.sv */
// Register interface types, control bit positions and the register offset enum
`default_nettype none

package scope_reg_pkg;

    // Byte offset carried with every register write strobe
    typedef logic [7:0] reg_addr_t;

    // Register write word
    typedef logic [31:0] reg_data_t;

    // Offsets of the writable registers
    // Selectors sit one word apart, the divider sits apart from them
    typedef enum reg_addr_t {
        CONTROL    = 8'h00,
        SELECTOR_0 = 8'h04,
        SELECTOR_1 = 8'h08,
        SELECTOR_2 = 8'h0c,
        SELECTOR_3 = 8'h10,
        DIVIDER    = 8'h20
    } reg_offset_e;

    // Arm bit in CONTROL, acted on at the write and never stored
    localparam int CONTROL_ARM_BIT = 0;

    // External capture bit in CONTROL, stored and sent to the timebase
    localparam int CONTROL_EXT_BIT = 24;

endpackage

`default_nettype wire

/* verilog/scope_macros.svh */
// Size macros for the stream scope: channel count, capture depth and divider width
`ifndef SCOPE_MACROS_SVH
`define SCOPE_MACROS_SVH

// Number of channel extractors, and so the number of samples in one buffer row
// The register map has one selector per channel, from SELECTOR_0 upwards
`define SCOPE_N_CHANNELS 4

// Number of rows taken by one armed capture
// The row index type is sized from this value, so it should stay a power of two
`define SCOPE_DEPTH 16

// Width of the internal timebase divider register and of its cycle counter
// Ticks come divider+1 cycles apart, so the slowest rate is one tick per 2^16 cycles
`define SCOPE_DIV_WIDTH 16

`endif
